// ==== hdl/ex_config.svh ====
////////////////////
// Global widths, register count and multiplier latency of the core
////////////////////
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// Data path
`define EX_XLEN           32  // Word width
`define EX_REG_ADDR_WIDTH 5   // Register index bits

// Register file
`define EX_NUM_REGS       32  // Includes hardwired x0

// Shift-add steps of one MUL
`define EX_MULT_CYCLES    4

`endif

// ==== hdl/ex_pkg.sv ====
////////////////////
// Core data types, ALU operators and pipeline register structs
////////////////////
`include "ex_config.svh"

package ex_pkg;

  typedef logic [`EX_XLEN-1:0]           word_t;      // One data word
  typedef logic [`EX_REG_ADDR_WIDTH-1:0] reg_addr_t;  // Register index

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_EQ,   // Branch compares
    ALU_NE
  } alu_op_e;

  typedef enum logic [1:0] {
    MULT_IDLE,
    MULT_RUN,
    MULT_DONE
  } mult_state_e;

  // ID/EX slot
  typedef struct packed {
    logic      valid;
    alu_op_e   alu_op;
    word_t     operand_a;  // rs1
    word_t     operand_b;  // rs2 or I immediate
    word_t     operand_c;  // B immediate, jump target
    logic      mult_en;
    logic      branch;
    logic      rf_we;
    reg_addr_t rf_waddr;
  } id_ex_t;

  // EX/WB slot
  typedef struct packed {
    logic      we;
    reg_addr_t waddr;
    word_t     wdata;
  } ex_wb_t;

endpackage

// ==== hdl/ex_alu.sv ====
////////////////////
// Single-cycle ALU with shared adder, logic ops, shifts and compares
////////////////////
`timescale 1ns/10ps
`include "ex_config.svh"

module ex_alu
(
  input  ex_pkg::alu_op_e operator_i,
  input  ex_pkg::word_t   operand_a_i,
  input  ex_pkg::word_t   operand_b_i,
  output ex_pkg::word_t   result_o,
  output logic            comparison_result_o  // Branch decision
);
  import ex_pkg::*;

  localparam int SHAMT_W = $clog2(`EX_XLEN);

  logic               sub;
  word_t              adder_b;
  logic [`EX_XLEN:0]  adder_sum;  // Carry out on top
  logic               lt_signed;
  logic               lt_unsigned;
  logic               equal;
  logic [SHAMT_W-1:0] shamt;

  ////////////////////
  // Adder
  ////////////////////
  // SUB and both set-less-than ops subtract
  assign sub       = (operator_i == ALU_SUB) || (operator_i == ALU_SLT)
                  || (operator_i == ALU_SLTU);
  assign adder_b   = sub ? ~operand_b_i : operand_b_i;
  assign adder_sum = {1'b0, operand_a_i} + {1'b0, adder_b} + {{`EX_XLEN{1'b0}}, sub};

  assign lt_unsigned = ~adder_sum[`EX_XLEN];  // Borrow out
  // Same signs use the difference, else sign of A decides
  assign lt_signed   = (operand_a_i[`EX_XLEN-1] == operand_b_i[`EX_XLEN-1])
                     ? adder_sum[`EX_XLEN-1] : operand_a_i[`EX_XLEN-1];

  assign equal               = (operand_a_i == operand_b_i);
  assign comparison_result_o = (operator_i == ALU_NE) ? ~equal : equal;

  assign shamt = operand_b_i[SHAMT_W-1:0];  // Modulo 32

  ////////////////////
  // Result mux
  ////////////////////
  always_comb
  begin
    case (operator_i)
      ALU_ADD,
      ALU_SUB:  result_o = adder_sum[`EX_XLEN-1:0];
      ALU_AND:  result_o = operand_a_i & operand_b_i;
      ALU_OR:   result_o = operand_a_i | operand_b_i;
      ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ALU_SLT:  result_o = word_t'(lt_signed);
      ALU_SLTU: result_o = word_t'(lt_unsigned);
      ALU_SLL:  result_o = operand_a_i << shamt;
      ALU_SRL:  result_o = operand_a_i >> shamt;  // Logical
      default:  result_o = word_t'(comparison_result_o);  // EQ and NE
    endcase
  end

endmodule

// ==== hdl/ex_mult.sv ====
////////////////////
// Iterative 32x32 low-word multiplier, one byte of B per cycle
////////////////////
`timescale 1ns/10ps
`include "ex_config.svh"

module ex_mult
(
  input  logic          clk,
  input  logic          rst_n,
  input  logic          enable_i,
  input  ex_pkg::word_t op_a_i,
  input  ex_pkg::word_t op_b_i,
  output ex_pkg::word_t result_o,
  output logic          ready_o,
  input  logic          ex_ready_i
);
  import ex_pkg::*;

  localparam int STEP_W = `EX_XLEN / `EX_MULT_CYCLES;  // Digit width
  localparam int CNT_W  = (`EX_MULT_CYCLES > 1) ? $clog2(`EX_MULT_CYCLES) : 1;
  localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`EX_MULT_CYCLES - 1);

  mult_state_e      state_q;
  logic [CNT_W-1:0] step_q;
  word_t            acc_q;
  word_t            a_q;   // Multiplicand, moves up a digit per step
  word_t            b_q;   // Multiplier, moves down a digit per step

  // Counter FSM
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= MULT_IDLE;
      step_q  <= '0;
    end
    else
    begin
      case (state_q)
        MULT_IDLE:
        begin
          step_q <= '0;
          if (enable_i)
            state_q <= MULT_RUN;
        end
        MULT_RUN:
        begin
          step_q <= step_q + 1'b1;
          if (step_q == LAST_STEP)
            state_q <= MULT_DONE;
        end
        MULT_DONE:
          if (ex_ready_i)
            state_q <= MULT_IDLE;  // Result taken into EX/WB
        default: state_q <= MULT_IDLE;
      endcase
    end
  end

  // Shift-add datapath
  always_ff @(posedge clk)
  begin
    if (state_q == MULT_IDLE)
    begin
      acc_q <= '0;
      a_q   <= op_a_i;
      b_q   <= op_b_i;
    end
    else if (state_q == MULT_RUN)
    begin
      acc_q <= acc_q + a_q * b_q[STEP_W-1:0];  // Low word only
      a_q   <= a_q << STEP_W;
      b_q   <= b_q >> STEP_W;
    end
  end

  assign result_o = acc_q;
  assign ready_o  = (state_q == MULT_DONE) || ((state_q == MULT_IDLE) && !enable_i);

  // ID/EX holds the MUL through the iterations
  assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == MULT_RUN) |-> (enable_i && $stable(op_a_i) && $stable(op_b_i)));

endmodule

// ==== hdl/op_decoder.sv ====
////////////////////
// Instruction decode, operand read, scoreboard and ID/EX register
////////////////////
`timescale 1ns/10ps
`include "ex_config.svh"

module op_decoder
(
  input  logic              clk,
  input  logic              rst_n,
  input  ex_pkg::word_t     instr_i,
  input  logic              instr_valid_i,
  output logic              ready_o,
  input  logic              ex_ready_i,
  output ex_pkg::reg_addr_t rs1_raddr_o,
  output ex_pkg::reg_addr_t rs2_raddr_o,
  input  ex_pkg::word_t     rs1_rdata_i,
  input  ex_pkg::word_t     rs2_rdata_i,
  input  logic              wb_we_i,     // Result stage write this cycle
  input  ex_pkg::reg_addr_t wb_waddr_i,
  output ex_pkg::id_ex_t    id_ex_o
);
  import ex_pkg::*;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  reg_addr_t               rd;
  word_t                   imm_i_type;
  word_t                   imm_b_type;
  alu_op_e                 dec_op;
  logic                    dec_mult, dec_branch, dec_we;
  logic                    use_imm, use_rs1, use_rs2;
  logic [`EX_NUM_REGS-1:0] pending_q;  // One bit per register with a write in flight
  logic [`EX_NUM_REGS-1:0] wb_clr, sb_set, busy;
  logic                    hazard, accept, id_ex_en;
  id_ex_t                  id_ex_q;

  assign rd          = instr_i[11:7];
  assign rs1_raddr_o = instr_i[19:15];
  assign rs2_raddr_o = instr_i[24:20];
  assign imm_i_type  = {{(`EX_XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_b_type  = {{(`EX_XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7],
                        instr_i[30:25], instr_i[11:8], 1'b0};

  ////////////////////
  // Opcode decode
  ////////////////////
  always_comb
  begin
    dec_op     = ALU_ADD;  // No-op by default
    dec_mult   = 1'b0;
    dec_branch = 1'b0;
    dec_we     = 1'b0;
    use_imm    = 1'b0;
    use_rs1    = 1'b0;
    use_rs2    = 1'b0;
    case (instr_i[6:0])
      OPC_OP:
      begin
        dec_we  = 1'b1;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        case ({instr_i[31:25], instr_i[14:12]})  // funct7, funct3
          10'b0000000_000: dec_op   = ALU_ADD;
          10'b0100000_000: dec_op   = ALU_SUB;
          10'b0000000_111: dec_op   = ALU_AND;
          10'b0000000_110: dec_op   = ALU_OR;
          10'b0000000_100: dec_op   = ALU_XOR;
          10'b0000000_010: dec_op   = ALU_SLT;
          10'b0000000_011: dec_op   = ALU_SLTU;
          10'b0000000_001: dec_op   = ALU_SLL;
          10'b0000000_101: dec_op   = ALU_SRL;
          10'b0000001_000: dec_mult = 1'b1;     // MUL
          default:
          begin
            dec_we  = 1'b0;
            use_rs1 = 1'b0;
            use_rs2 = 1'b0;
          end
        endcase
      end
      OPC_OP_IMM:
      begin
        dec_we  = (instr_i[14:12] == 3'b000);  // ADDI only
        use_rs1 = dec_we;
        use_imm = 1'b1;
      end
      OPC_BRANCH:
      begin
        dec_branch = (instr_i[14:13] == 2'b00);  // BEQ and BNE
        dec_op     = instr_i[12] ? ALU_NE : ALU_EQ;
        use_rs1    = dec_branch;
        use_rs2    = dec_branch;
      end
      default: dec_op = ALU_ADD;
    endcase
  end

  ////////////////////
  // Scoreboard
  ////////////////////
  always_comb
  begin
    wb_clr = '0;
    sb_set = '0;
    if (wb_we_i)
      wb_clr[wb_waddr_i] = 1'b1;
    if (accept && dec_we && (rd != '0))
      sb_set[rd] = 1'b1;  // x0 never pending
  end

  assign busy     = pending_q & ~wb_clr;  // Retiring write comes through the bypass
  assign hazard   = (use_rs1 & busy[rs1_raddr_o]) | (use_rs2 & busy[rs2_raddr_o])
                  | (dec_we & busy[rd]);  // Also wait on rd so bits clear in order
  assign id_ex_en = ~id_ex_q.valid | ex_ready_i;
  assign ready_o  = id_ex_en & ~hazard;
  assign accept   = instr_valid_i & ready_o;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      pending_q <= '0;
    else
      pending_q <= busy | sb_set;
  end

  // ID/EX register
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      id_ex_q <= '0;
    else if (id_ex_en)
    begin
      id_ex_q.valid     <= accept;  // Empty slot when nothing taken
      id_ex_q.alu_op    <= dec_op;
      id_ex_q.operand_a <= rs1_rdata_i;
      id_ex_q.operand_b <= use_imm ? imm_i_type : rs2_rdata_i;
      id_ex_q.operand_c <= imm_b_type;
      id_ex_q.mult_en   <= dec_mult;
      id_ex_q.branch    <= dec_branch;
      id_ex_q.rf_we     <= dec_we;
      id_ex_q.rf_waddr  <= rd;
    end
  end

  assign id_ex_o = id_ex_q;

  // Slot frozen while execute stalls
  assert property (@(posedge clk) disable iff (!rst_n)
    (id_ex_q.valid && !ex_ready_i) |=> $stable(id_ex_q));

  // Every register write was announced at accept
  assert property (@(posedge clk) disable iff (!rst_n)
    (wb_we_i && (wb_waddr_i != '0)) |-> pending_q[wb_waddr_i]);

endmodule

// ==== hdl/ex_stage.sv ====
////////////////////
// Execute stage with ALU, multiplier, branch outputs and EX/WB register
////////////////////
`timescale 1ns/10ps

module ex_stage
(
  input  logic           clk,
  input  logic           rst_n,
  input  ex_pkg::id_ex_t id_ex_i,
  output logic           ex_ready_o,
  output ex_pkg::ex_wb_t ex_wb_o,
  output logic           branch_valid_o,
  output logic           branch_taken_o,
  output ex_pkg::word_t  branch_target_o
);
  import ex_pkg::*;

  word_t  alu_result;
  word_t  mult_result;
  word_t  ex_result;
  logic   alu_cmp_result;
  logic   mult_ready;
  logic   mult_active;
  logic   branch_in_ex;
  logic   ex_valid;
  ex_wb_t ex_wb_q;

  assign mult_active  = id_ex_i.valid & id_ex_i.mult_en;
  assign branch_in_ex = id_ex_i.valid & id_ex_i.branch;

  ////////////////////
  // ALU and multiplier
  ////////////////////
  ex_alu u_alu
  (
    .operator_i          (id_ex_i.alu_op),
    .operand_a_i         (id_ex_i.operand_a),
    .operand_b_i         (id_ex_i.operand_b),
    .result_o            (alu_result),
    .comparison_result_o (alu_cmp_result)
  );

  ex_mult u_mult
  (
    .clk        (clk),
    .rst_n      (rst_n),
    .enable_i   (mult_active),
    .op_a_i     (id_ex_i.operand_a),
    .op_b_i     (id_ex_i.operand_b),
    .result_o   (mult_result),
    .ready_o    (mult_ready),
    .ex_ready_i (ex_ready_o)
  );

  assign ex_result = id_ex_i.mult_en ? mult_result : alu_result;

  // Branches finish here so they never wait on the multiplier
  assign ex_valid   = mult_ready & id_ex_i.valid & ~id_ex_i.branch;
  assign ex_ready_o = mult_ready | branch_in_ex;

  assign branch_valid_o  = branch_in_ex;        // One cycle per branch
  assign branch_taken_o  = alu_cmp_result;
  assign branch_target_o = id_ex_i.operand_c;   // Immediate passed through

  ////////////////////
  // EX/WB register
  ////////////////////
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      ex_wb_q <= '0;
    else if (ex_valid)
    begin
      ex_wb_q.we    <= id_ex_i.rf_we;
      ex_wb_q.waddr <= id_ex_i.rf_waddr;
      ex_wb_q.wdata <= ex_result;
    end
    else
      ex_wb_q.we <= 1'b0;  // Nothing ready, flush the slot
  end

  assign ex_wb_o = ex_wb_q;

  // Decoded branch carries no register write and no multiply
  assert property (@(posedge clk) disable iff (!rst_n)
    branch_in_ex |-> (!id_ex_i.rf_we && !id_ex_i.mult_en));

endmodule

// ==== hdl/wb_regfile.sv ====
////////////////////
// Result stage with register file, bypassed read ports and retire port
////////////////////
`timescale 1ns/10ps
`include "ex_config.svh"

module wb_regfile
(
  input  logic              clk,
  input  logic              rst_n,
  input  ex_pkg::ex_wb_t    ex_wb_i,
  input  ex_pkg::reg_addr_t rs1_raddr_i,
  input  ex_pkg::reg_addr_t rs2_raddr_i,
  output ex_pkg::word_t     rs1_rdata_o,
  output ex_pkg::word_t     rs2_rdata_o,
  output logic              wb_we_o,
  output ex_pkg::reg_addr_t wb_waddr_o,
  output ex_pkg::word_t     wb_wdata_o
);
  import ex_pkg::*;

  word_t regs_q [`EX_NUM_REGS];  // Entry 0 stays zero

  // x0 first, then the write in progress, then storage
  function automatic word_t read_reg(reg_addr_t addr);
    word_t data;
    if (addr == '0)
      data = '0;
    else if (ex_wb_i.we && (ex_wb_i.waddr == addr))
      data = ex_wb_i.wdata;  // Same-cycle bypass
    else
      data = regs_q[addr];
    return data;
  endfunction

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < `EX_NUM_REGS; i++)
        regs_q[i] <= '0;
    end
    else if (ex_wb_i.we && (ex_wb_i.waddr != '0))
      regs_q[ex_wb_i.waddr] <= ex_wb_i.wdata;
  end

  always_comb
  begin
    rs1_rdata_o = read_reg(rs1_raddr_i);
    rs2_rdata_o = read_reg(rs2_raddr_i);
  end

  // Retire port mirrors the write
  assign wb_we_o    = ex_wb_i.we;
  assign wb_waddr_o = ex_wb_i.waddr;
  assign wb_wdata_o = ex_wb_i.wdata;

endmodule

// ==== hdl/core_ex_top.sv ====
////////////////////
// Core top with decoder, execute stage and result stage
////////////////////
`timescale 1ns/10ps

module core_ex_top
(
  input  logic              clk,
  input  logic              rst_n,
  input  ex_pkg::word_t     instr_i,
  input  logic              instr_valid_i,
  output logic              ready_o,
  output logic              retire_we_o,
  output ex_pkg::reg_addr_t retire_waddr_o,
  output ex_pkg::word_t     retire_wdata_o,
  output logic              branch_valid_o,
  output logic              branch_taken_o,
  output ex_pkg::word_t     branch_target_o
);
  import ex_pkg::*;

  id_ex_t    id_ex;     // Decode to execute
  ex_wb_t    ex_wb;     // Execute to result
  logic      ex_ready;
  reg_addr_t rs1_raddr;
  reg_addr_t rs2_raddr;
  word_t     rs1_rdata;
  word_t     rs2_rdata;

  op_decoder u_decoder
  (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .ready_o       (ready_o),
    .ex_ready_i    (ex_ready),
    .rs1_raddr_o   (rs1_raddr),
    .rs2_raddr_o   (rs2_raddr),
    .rs1_rdata_i   (rs1_rdata),
    .rs2_rdata_i   (rs2_rdata),
    .wb_we_i       (retire_we_o),     // Scoreboard clear
    .wb_waddr_i    (retire_waddr_o),
    .id_ex_o       (id_ex)
  );

  ex_stage u_ex
  (
    .clk             (clk),
    .rst_n           (rst_n),
    .id_ex_i         (id_ex),
    .ex_ready_o      (ex_ready),
    .ex_wb_o         (ex_wb),
    .branch_valid_o  (branch_valid_o),
    .branch_taken_o  (branch_taken_o),
    .branch_target_o (branch_target_o)
  );

  wb_regfile u_wb
  (
    .clk         (clk),
    .rst_n       (rst_n),
    .ex_wb_i     (ex_wb),
    .rs1_raddr_i (rs1_raddr),
    .rs2_raddr_i (rs2_raddr),
    .rs1_rdata_o (rs1_rdata),
    .rs2_rdata_o (rs2_rdata),
    .wb_we_o     (retire_we_o),
    .wb_waddr_o  (retire_waddr_o),
    .wb_wdata_o  (retire_wdata_o)
  );

endmodule

// ==== dv/core_ex_tb.sv ====
////////////////////
// Testbench for the core with a random program, a register model
// and assertion checks
////////////////////
`timescale 1ns/10ps
`include "ex_config.svh"

module core_ex_tb;
  import ex_pkg::*;

  localparam int          CLK_PERIOD   = 100;
  localparam int          RESET_CYCLES = 5;
  localparam int          NUM_INSTR    = 300;  // Preload included
  localparam int          NUM_PRELOAD  = 8;
  localparam int          MAX_CYCLES   = NUM_INSTR * (`EX_MULT_CYCLES + 4) + 100;
  localparam logic [31:0] SEED         = 32'hbac4_d2ba;

  // Instruction kinds of the random program
  localparam logic [3:0] K_ADD  = 4'd0;
  localparam logic [3:0] K_SUB  = 4'd1;
  localparam logic [3:0] K_AND  = 4'd2;
  localparam logic [3:0] K_OR   = 4'd3;
  localparam logic [3:0] K_XOR  = 4'd4;
  localparam logic [3:0] K_SLT  = 4'd5;
  localparam logic [3:0] K_SLTU = 4'd6;
  localparam logic [3:0] K_SLL  = 4'd7;
  localparam logic [3:0] K_SRL  = 4'd8;
  localparam logic [3:0] K_MUL  = 4'd9;
  localparam logic [3:0] K_ADDI = 4'd10;
  localparam logic [3:0] K_BEQ  = 4'd11;
  localparam logic [3:0] K_BNE  = 4'd12;

  typedef struct packed {
    logic [3:0] kind;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    word_t      imm;  // I or B immediate, sign extended
  } tb_instr_t;

  typedef struct packed {
    reg_addr_t waddr;
    word_t     wdata;
  } retire_t;

  logic      clk;
  logic      rst_n;
  word_t     instr_i;
  logic      instr_valid_i;
  logic      ready_o;
  logic      retire_we_o;
  reg_addr_t retire_waddr_o;
  word_t     retire_wdata_o;
  logic      branch_valid_o;
  logic      branch_taken_o;
  word_t     branch_target_o;

  // Reference model
  word_t     model_regs [`EX_NUM_REGS];
  retire_t   ret_q [$];      // Expected retirements, oldest first
  retire_t   exp_ret;        // Head of the queue
  logic      exp_ret_avail;
  logic      exp_br_taken;
  word_t     exp_br_target;
  logic      br_acc_d;       // Branch taken in at the last edge
  logic      alu_acc_d;      // ALU op taken in with nothing in flight
  int        mul_wait;       // Cycles left with ready_o forced low
  tb_instr_t cur;            // Instruction on instr_i
  logic      accepted;
  int        cycle_cnt;

  core_ex_top u_dut
  (
    .clk             (clk),
    .rst_n           (rst_n),
    .instr_i         (instr_i),
    .instr_valid_i   (instr_valid_i),
    .ready_o         (ready_o),
    .retire_we_o     (retire_we_o),
    .retire_waddr_o  (retire_waddr_o),
    .retire_wdata_o  (retire_wdata_o),
    .branch_valid_o  (branch_valid_o),
    .branch_taken_o  (branch_taken_o),
    .branch_target_o (branch_target_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  ////////////////////
  // Encoding and RV32IM semantics
  ////////////////////
  function automatic word_t r_type(logic [6:0] funct7, logic [2:0] funct3, tb_instr_t ins);
    return {funct7, ins.rs2, ins.rs1, funct3, ins.rd, 7'b0110011};
  endfunction

  function automatic word_t encode(tb_instr_t ins);
    word_t w;
    case (ins.kind)
      K_ADD:   w = r_type(7'h00, 3'b000, ins);
      K_SUB:   w = r_type(7'h20, 3'b000, ins);
      K_AND:   w = r_type(7'h00, 3'b111, ins);
      K_OR:    w = r_type(7'h00, 3'b110, ins);
      K_XOR:   w = r_type(7'h00, 3'b100, ins);
      K_SLT:   w = r_type(7'h00, 3'b010, ins);
      K_SLTU:  w = r_type(7'h00, 3'b011, ins);
      K_SLL:   w = r_type(7'h00, 3'b001, ins);
      K_SRL:   w = r_type(7'h00, 3'b101, ins);
      K_MUL:   w = r_type(7'h01, 3'b000, ins);
      K_ADDI:  w = {ins.imm[11:0], ins.rs1, 3'b000, ins.rd, 7'b0010011};
      default: w = {ins.imm[12], ins.imm[10:5], ins.rs2, ins.rs1, 2'b00, ins.kind == K_BNE,
                    ins.imm[4:1], ins.imm[11], 7'b1100011};  // BEQ, BNE
    endcase
    return w;
  endfunction

  function automatic word_t expected_value(logic [3:0] kind, word_t a, word_t b);
    word_t res;
    case (kind)
      K_ADD,
      K_ADDI:  res = a + b;
      K_SUB:   res = a - b;
      K_AND:   res = a & b;
      K_OR:    res = a | b;
      K_XOR:   res = a ^ b;
      K_SLT:   res = ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
      K_SLTU:  res = (a < b) ? word_t'(1) : word_t'(0);
      K_SLL:   res = a << b[4:0];  // Amount modulo 32
      K_SRL:   res = a >> b[4:0];
      K_MUL:   res = a * b;        // Low word of the product
      default: res = '0;
    endcase
    return res;
  endfunction

  function automatic tb_instr_t preload_instr(reg_addr_t rd);
    tb_instr_t   ins;
    logic [31:0] r;
    r        = $urandom;
    ins      = '0;
    ins.kind = K_ADDI;
    ins.rd   = rd;  // x0 too, must stay zero
    ins.imm  = {{20{r[11]}}, r[11:0]};
    return ins;
  endfunction

  // x0 to x7 only, so hazards come often
  function automatic tb_instr_t random_instr();
    tb_instr_t   ins;
    logic [31:0] r;
    r        = $urandom;
    ins.kind = 4'($urandom_range(12, 0));
    ins.rd   = reg_addr_t'($urandom_range(7, 0));
    ins.rs1  = reg_addr_t'($urandom_range(7, 0));
    ins.rs2  = reg_addr_t'($urandom_range(7, 0));
    if (ins.kind == K_ADDI)
      ins.imm = {{20{r[11]}}, r[11:0]};
    else
      ins.imm = {{19{r[12]}}, r[12:1], 1'b0};  // Even branch offset
    return ins;
  endfunction

  // Model update at the edge that takes the instruction
  task automatic accept_instr(input tb_instr_t ins);
    word_t   a;
    word_t   b;
    retire_t ent;
    a = model_regs[ins.rs1];
    b = (ins.kind == K_ADDI) ? ins.imm : model_regs[ins.rs2];
    if ((ins.kind == K_BEQ) || (ins.kind == K_BNE))
    begin
      exp_br_taken  = (ins.kind == K_BEQ) ? (a == b) : (a != b);
      exp_br_target = ins.imm;
      br_acc_d      = 1'b1;
    end
    else
    begin
      ent.waddr = ins.rd;
      ent.wdata = expected_value(ins.kind, a, b);
      alu_acc_d = (ret_q.size() == 0) && (ins.kind != K_MUL);
      ret_q.push_back(ent);
      if (ins.rd != '0)
        model_regs[ins.rd] = ent.wdata;
      if (ins.kind == K_MUL)
        mul_wait = `EX_MULT_CYCLES;
    end
  endtask

  ////////////////////
  // Monitor
  ////////////////////
  always @(posedge clk)
  begin
    if (rst_n)
    begin
      if (retire_we_o && (ret_q.size() > 0))
        void'(ret_q.pop_front());  // Checked by the assertion this edge
      br_acc_d  = 1'b0;
      alu_acc_d = 1'b0;
      if (mul_wait > 0)
        mul_wait--;
      accepted = instr_valid_i && ready_o;
      if (accepted)
        accept_instr(cur);
      exp_ret_avail = (ret_q.size() > 0);
      if (exp_ret_avail)
        exp_ret = ret_q[0];
    end
  end

  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES)
      stop_on_error($sformatf("Timeout: program not finished after %0d cycles", MAX_CYCLES));
  end

  ////////////////////
  // Checks
  ////////////////////
  a_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> (!retire_we_o && !branch_valid_o && ready_o))
    else stop_on_error($sformatf("[FAIL] %0t: outputs wrong right after reset", $time));

  a_retire: assert property (@(posedge clk) disable iff (!rst_n)
    retire_we_o |-> (exp_ret_avail && (retire_waddr_o == exp_ret.waddr)
                     && (retire_wdata_o == exp_ret.wdata)))
    else stop_on_error($sformatf("[FAIL] %0t: retired x%0d=%h, expected x%0d=%h (pending %0b)",
      $time, $sampled(retire_waddr_o), $sampled(retire_wdata_o),
      $sampled(exp_ret.waddr), $sampled(exp_ret.wdata), $sampled(exp_ret_avail)));

  a_mul_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (mul_wait != 0) |-> !ready_o)
    else stop_on_error($sformatf("[FAIL] %0t: ready_o high during MUL iterations", $time));

  a_branch_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    branch_valid_o == br_acc_d)
    else stop_on_error($sformatf("[FAIL] %0t: branch_valid_o is %0b, expected %0b",
      $time, $sampled(branch_valid_o), $sampled(br_acc_d)));

  a_branch_value: assert property (@(posedge clk) disable iff (!rst_n)
    branch_valid_o |-> ((branch_taken_o == exp_br_taken) && (branch_target_o == exp_br_target)))
    else stop_on_error($sformatf("[FAIL] %0t: branch taken=%0b target=%h, expected %0b %h",
      $time, $sampled(branch_taken_o), $sampled(branch_target_o),
      $sampled(exp_br_taken), $sampled(exp_br_target)));

  a_branch_no_retire: assert property (@(posedge clk) disable iff (!rst_n)
    branch_valid_o |=> !retire_we_o)
    else stop_on_error($sformatf("[FAIL] %0t: branch produced a retirement", $time));

  // Empty pipeline, ALU op retires two edges after accept
  a_alu_early: assert property (@(posedge clk) disable iff (!rst_n)
    alu_acc_d |-> !retire_we_o)
    else stop_on_error($sformatf("[FAIL] %0t: ALU op retired after 1 cycle", $time));

  a_alu_latency: assert property (@(posedge clk) disable iff (!rst_n)
    alu_acc_d |=> retire_we_o)
    else stop_on_error($sformatf("[FAIL] %0t: ALU op not retired after 2 cycles", $time));

  a_x0_read: assert property (@(posedge clk) disable iff (!rst_n)
    ((u_dut.rs1_raddr != '0) || (u_dut.rs1_rdata == '0))
    && ((u_dut.rs2_raddr != '0) || (u_dut.rs2_rdata == '0)))
    else stop_on_error($sformatf("[FAIL] %0t: nonzero value read from x0", $time));

  ////////////////////
  // Stimulus
  ////////////////////
  initial
  begin
    void'($urandom(SEED));
    rst_n         = 1'b0;
    instr_i       = '0;
    instr_valid_i = 1'b0;
    cur           = '0;
    accepted      = 1'b0;
    br_acc_d      = 1'b0;
    alu_acc_d     = 1'b0;
    mul_wait      = 0;
    exp_ret       = '0;
    exp_ret_avail = 1'b0;
    exp_br_taken  = 1'b0;
    exp_br_target = '0;
    cycle_cnt     = 0;
    for (int i = 0; i < `EX_NUM_REGS; i++)
      model_regs[i] = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    for (int n = 0; n < NUM_INSTR; n++)
    begin
      if (n < NUM_PRELOAD)
        cur = preload_instr(reg_addr_t'(n));
      else
        cur = random_instr();
      if ((n >= NUM_PRELOAD) && ($urandom_range(7, 0) == 0))
      begin
        instr_valid_i = 1'b0;  // Idle gap
        @(negedge clk);
      end
      instr_i       = encode(cur);
      instr_valid_i = 1'b1;
      do
        @(negedge clk);  // Held until taken
      while (!accepted);
    end
    instr_valid_i = 1'b0;

    // Drain, timeout guards a stuck pipeline
    while (ret_q.size() != 0)
      @(negedge clk);
    repeat (2) @(negedge clk);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+hdl
hdl/ex_pkg.sv
hdl/ex_alu.sv
hdl/ex_mult.sv
hdl/op_decoder.sv
hdl/ex_stage.sv
hdl/wb_regfile.sv
hdl/core_ex_top.sv
dv/core_ex_tb.sv

// ==== Bender.yml ====
package:
  name: core_ex

export_include_dirs:
  - hdl

sources:
  - hdl/ex_pkg.sv
  - hdl/ex_alu.sv
  - hdl/ex_mult.sv
  - hdl/op_decoder.sv
  - hdl/ex_stage.sv
  - hdl/wb_regfile.sv
  - hdl/core_ex_top.sv
  - target: test
    files:
      - dv/core_ex_tb.sv
